// ==== hw/exe_defs.svh ====
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// data path width
`define WORD_W 32

// register file index
`define REG_IDX_W 5

// immediate field of an I-type instruction
`define IMM_W 16

// one strobe bit per byte lane
`define STRB_W 4

// shift amount sits in imm[10:6]
`define SA_LSB 6
`define SA_MSB 10

`endif

// ==== hw/exe_pkg.sv ====
`include "exe_defs.svh"

package exe_pkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`IMM_W-1:0]     imm_t;
    typedef logic [`STRB_W-1:0]    strb_t;
    typedef logic [1:0]            acc_size_t; // 0 byte, 1 half, 2 word

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or,  alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // left/right cover swl/lwl and swr/lwr
    typedef enum logic [2:0] {
        mem_none, mem_word, mem_half, mem_byte, mem_left, mem_right
    } mem_width_e;

    typedef enum logic [2:0] {
        hilo_none, hilo_mult, hilo_multu, hilo_mthi, hilo_mtlo, hilo_mfhi, hilo_mflo
    } hilo_op_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       src1_is_sa;
        logic       src1_is_pc;
        logic       src2_is_imm;
        logic       src2_is_8;
        logic       of_check;   // add/addi/sub trap on overflow
        logic       gpr_we;
        logic       mem_re;
        logic       mem_we;
        mem_width_e mem_width;
        hilo_op_e   hilo_op;
        reg_idx_t   dest;
        imm_t       imm;
        word_t      rs_value;
        word_t      rt_value;
        word_t      pc;
    } ds_to_es_t;

    typedef struct packed {
        word_t      result;
        reg_idx_t   dest;
        logic       gpr_we;
        logic       mem_re;
        mem_width_e mem_width;
        logic [1:0] addr_lo;    // load byte select in mem stage
        word_t      rt_value;
        word_t      pc;
        logic       exc_of;
        logic       exc_adel;
        logic       exc_ades;
    } es_to_ms_t;

    typedef struct packed {
        logic     active;
        logic     res_valid;  // low while a load result is pending
        reg_idx_t dest;
        word_t    result;
    } es_fwd_t;

    typedef struct packed {
        logic      wr;
        acc_size_t size;
        word_t     addr;
        strb_t     wstrb;
        word_t     wdata;
    } data_req_t;

endpackage

// ==== hw/exe_alu.sv ====
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_alu import exe_pkg::*; (
    input  ds_to_es_t inst_i,
    output word_t     src1_o,
    output word_t     src2_o,
    output word_t     result_o,
    output logic      overflow_o
);

    logic  imm_unsigned;
    word_t imm_ext;
    word_t sum;
    word_t diff;
    logic  add_of;
    logic  sub_of;

    // andi, ori and xori take a zero-extended immediate
    assign imm_unsigned = inst_i.alu_op inside {alu_and, alu_or, alu_xor};
    assign imm_ext      = {{(`WORD_W-`IMM_W){~imm_unsigned & inst_i.imm[`IMM_W-1]}},
                           inst_i.imm};

    always_comb begin
        if (inst_i.src1_is_sa) begin
            src1_o = {{(`WORD_W-(`SA_MSB-`SA_LSB+1)){1'b0}},
                      inst_i.imm[`SA_MSB:`SA_LSB]};
        end else if (inst_i.src1_is_pc) begin
            src1_o = inst_i.pc;       // link address base
        end else begin
            src1_o = inst_i.rs_value;
        end
    end

    always_comb begin
        if (inst_i.src2_is_imm) begin
            src2_o = imm_ext;
        end else if (inst_i.src2_is_8) begin
            src2_o = `WORD_W'd8;      // pc + 8 for jal/bal
        end else begin
            src2_o = inst_i.rt_value;
        end
    end

    assign sum  = src1_o + src2_o;
    assign diff = src1_o - src2_o;

    // signed overflow from the operand and result sign bits
    assign add_of = (src1_o[`WORD_W-1] == src2_o[`WORD_W-1])
                  & (sum[`WORD_W-1]    != src1_o[`WORD_W-1]);
    assign sub_of = (src1_o[`WORD_W-1] != src2_o[`WORD_W-1])
                  & (diff[`WORD_W-1]   != src1_o[`WORD_W-1]);

    assign overflow_o = inst_i.of_check
                      & ((inst_i.alu_op == alu_add) & add_of
                       | (inst_i.alu_op == alu_sub) & sub_of);

    always_comb begin
        case (inst_i.alu_op)
            alu_add:  result_o = sum;
            alu_sub:  result_o = diff;
            alu_slt:  result_o = {{(`WORD_W-1){1'b0}}, $signed(src1_o) < $signed(src2_o)};
            alu_sltu: result_o = {{(`WORD_W-1){1'b0}}, src1_o < src2_o};
            alu_and:  result_o = src1_o & src2_o;
            alu_nor:  result_o = ~(src1_o | src2_o);
            alu_or:   result_o = src1_o | src2_o;
            alu_xor:  result_o = src1_o ^ src2_o;
            alu_sll:  result_o = src2_o << src1_o[4:0];  // shifts act on src2
            alu_srl:  result_o = src2_o >> src1_o[4:0];
            alu_sra:  result_o = $signed(src2_o) >>> src1_o[4:0];
            alu_lui:  result_o = {src2_o[`IMM_W-1:0], {(`WORD_W-`IMM_W){1'b0}}};
            default:  result_o = '0;
        endcase
    end

    // decode must only hand over one of the twelve encodings
    always_comb begin
        if (!$isunknown(inst_i.alu_op)) begin
            alu_op_legal: assert (inst_i.alu_op <= alu_lui);
        end
    end

endmodule

// ==== hw/store_align.sv ====
`timescale 1ns/1ps

module store_align import exe_pkg::*; (
    input  mem_width_e mem_width_i,
    input  logic       mem_re_i,
    input  logic       mem_we_i,
    input  logic [1:0] addr_lo_i,
    input  word_t      rt_value_i,
    output strb_t      wstrb_o,
    output word_t      wdata_o,
    output acc_size_t  size_o,
    output logic       exc_adel_o,
    output logic       exc_ades_o
);

    logic [2:0] strb_cnt;
    logic       misaligned;

    always_comb begin
        case (mem_width_i)
            mem_byte: begin
                wstrb_o = strb_t'(1) << addr_lo_i;
                wdata_o = {4{rt_value_i[7:0]}};           // replicate to every lane
            end
            mem_half: begin
                wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{rt_value_i[15:0]}};
            end
            mem_word: begin
                wstrb_o = 4'b1111;
                wdata_o = rt_value_i;
            end
            mem_left: begin
                // swl writes the upper bytes of rt down to the address
                wstrb_o = 4'b1111 >> (2'd3 - addr_lo_i);
                wdata_o = rt_value_i >> {2'd3 - addr_lo_i, 3'b000};
            end
            mem_right: begin
                wstrb_o = 4'b1111 << addr_lo_i;
                wdata_o = rt_value_i << {addr_lo_i, 3'b000};
            end
            default: begin
                wstrb_o = '0;
                wdata_o = rt_value_i;
            end
        endcase
    end

    assign strb_cnt = 3'(wstrb_o[0]) + 3'(wstrb_o[1]) + 3'(wstrb_o[2]) + 3'(wstrb_o[3]);

    // three-byte swl/swr go out as word accesses
    assign size_o = (strb_cnt == 3'd1) ? 2'd0
                  : (strb_cnt == 3'd2) ? 2'd1
                  :                      2'd2;

    assign misaligned = (mem_width_i == mem_half) & addr_lo_i[0]
                      | (mem_width_i == mem_word) & (|addr_lo_i);

    assign exc_adel_o = mem_re_i & misaligned;
    assign exc_ades_o = mem_we_i & misaligned;

endmodule

// ==== hw/hilo_unit.sv ====
`timescale 1ns/1ps

module hilo_unit import exe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  hilo_op_e hilo_op_i,
    input  word_t    src1_i,
    input  word_t    src2_i,
    input  word_t    rs_value_i,
    input  logic     commit_i,
    output word_t    hilo_read_o,
    output logic     is_hilo_read_o
);

    word_t       hi;
    word_t       lo;
    logic        is_signed;
    logic [32:0] mul_a;
    logic [32:0] mul_b;
    logic [65:0] product;

    // one 33-bit signed multiplier serves both mult and multu
    assign is_signed = (hilo_op_i == hilo_mult);
    assign mul_a     = {is_signed & src1_i[31], src1_i};
    assign mul_b     = {is_signed & src2_i[31], src2_i};
    assign product   = $signed(mul_a) * $signed(mul_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit_i) begin
            case (hilo_op_i)
                hilo_mult, hilo_multu: begin
                    hi <= product[63:32];
                    lo <= product[31:0];
                end
                hilo_mthi: hi <= rs_value_i;
                hilo_mtlo: lo <= rs_value_i;
                default: ;                     // mfhi/mflo only read
            endcase
        end
    end

    assign is_hilo_read_o = (hilo_op_i == hilo_mfhi) | (hilo_op_i == hilo_mflo);
    assign hilo_read_o    = (hilo_op_i == hilo_mfhi) ? hi
                          : (hilo_op_i == hilo_mflo) ? lo
                          : '0;

    // the stage only commits instructions that touch HI/LO
    commit_needs_op: assert property (
        @(posedge clk) disable iff (reset)
        commit_i |-> (hilo_op_i != hilo_none)
    );

endmodule

// ==== hw/mem_req_ctrl.sv ====
`timescale 1ns/1ps

module mem_req_ctrl import exe_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic mem_access_i,
    input  logic cancel_i,
    input  logic addr_ok_i,
    input  logic leave_i,
    output logic req_o,
    output logic accepted_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_o <= 1'b0;
        end else if (cancel_i) begin
            req_o <= 1'b0;                 // withdraw a pending request
        end else if (req_o && addr_ok_i) begin
            req_o <= 1'b0;
        end else if (!req_o && !accepted_o) begin
            req_o <= mem_access_i;         // one request per instruction
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accepted_o <= 1'b0;
        end else if (leave_i) begin
            accepted_o <= 1'b0;
        end else if (req_o && addr_ok_i) begin
            accepted_o <= 1'b1;
        end
    end

    // a raised request always belongs to a memory instruction still in the stage
    req_has_owner: assert property (
        @(posedge clk) disable iff (reset)
        req_o |-> mem_access_i
    );

endmodule

// ==== hw/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_to_es_valid_i,
    input  ds_to_es_t ds_to_es_i,
    input  logic      ms_allowin_i,
    input  logic      exc_flush_i,
    input  logic      ms_ex_i,
    input  logic      data_addr_ok_i,
    output logic      es_allowin_o,
    output logic      es_to_ms_valid_o,
    output es_to_ms_t es_to_ms_o,
    output es_fwd_t   es_fwd_o,
    output logic      data_req_o,
    output data_req_t data_req_data_o
);

    logic      es_valid;
    ds_to_es_t inst_r;
    logic      ready_go;
    logic      ignore;
    logic      mem_op;
    logic      accepted;
    logic      leave;
    logic      commit;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     alu_result;
    logic      exc_of;
    strb_t     strb;
    word_t     wdata;
    acc_size_t size;
    logic      exc_adel;
    logic      exc_ades;
    word_t     hilo_read;
    logic      is_hilo_read;
    word_t     result;
    logic      req_wr;

    always_ff @(posedge clk) begin
        if (reset || exc_flush_i) begin
            es_valid <= 1'b0;
        end else if (es_allowin_o) begin
            es_valid <= ds_to_es_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid_i && es_allowin_o) begin
            inst_r <= ds_to_es_i;
        end
    end

    exe_alu u_alu (
        .inst_i    (inst_r),
        .src1_o    (alu_src1),
        .src2_o    (alu_src2),
        .result_o  (alu_result),
        .overflow_o(exc_of)
    );

    store_align u_store_align (
        .mem_width_i(inst_r.mem_width),
        .mem_re_i   (inst_r.mem_re),
        .mem_we_i   (inst_r.mem_we),
        .addr_lo_i  (alu_result[1:0]),
        .rt_value_i (inst_r.rt_value),
        .wstrb_o    (strb),
        .wdata_o    (wdata),
        .size_o     (size),
        .exc_adel_o (exc_adel),
        .exc_ades_o (exc_ades)
    );

    // later stages or this one's own trap kill side effects
    assign ignore = exc_flush_i | ms_ex_i | exc_of | exc_adel | exc_ades;
    assign mem_op = inst_r.mem_re | inst_r.mem_we;

    assign ready_go         = !mem_op || accepted || exc_adel || exc_ades;
    assign es_allowin_o     = !es_valid || (ready_go && ms_allowin_i);
    assign es_to_ms_valid_o = es_valid && ready_go;
    assign leave            = (es_to_ms_valid_o && ms_allowin_i) || exc_flush_i; // or flushed

    assign commit = es_valid && !ignore && (inst_r.hilo_op != hilo_none);

    hilo_unit u_hilo (
        .clk           (clk),
        .reset         (reset),
        .hilo_op_i     (inst_r.hilo_op),
        .src1_i        (alu_src1),
        .src2_i        (alu_src2),
        .rs_value_i    (inst_r.rs_value),
        .commit_i      (commit),
        .hilo_read_o   (hilo_read),
        .is_hilo_read_o(is_hilo_read)
    );

    mem_req_ctrl u_req (
        .clk         (clk),
        .reset       (reset),
        .mem_access_i(es_valid & mem_op),
        .cancel_i    (ignore),
        .addr_ok_i   (data_addr_ok_i),
        .leave_i     (leave),
        .req_o       (data_req_o),
        .accepted_o  (accepted)
    );

    assign result = is_hilo_read ? hilo_read : alu_result;
    assign req_wr = inst_r.mem_we & ~ignore;

    always_comb begin
        data_req_data_o.wr    = req_wr;
        data_req_data_o.size  = size;
        data_req_data_o.addr  = alu_result;           // no address translation
        data_req_data_o.wstrb = req_wr ? strb : '0;    // loads carry no strobe
        data_req_data_o.wdata = wdata;
    end

    always_comb begin
        es_to_ms_o.result    = result;
        es_to_ms_o.dest      = inst_r.dest;
        es_to_ms_o.gpr_we    = inst_r.gpr_we;
        es_to_ms_o.mem_re    = inst_r.mem_re;
        es_to_ms_o.mem_width = inst_r.mem_width;
        es_to_ms_o.addr_lo   = alu_result[1:0];
        es_to_ms_o.rt_value  = inst_r.rt_value;
        es_to_ms_o.pc        = inst_r.pc;
        es_to_ms_o.exc_of    = exc_of;
        es_to_ms_o.exc_adel  = exc_adel;
        es_to_ms_o.exc_ades  = exc_ades;
    end

    always_comb begin
        if (es_valid && inst_r.gpr_we) begin
            es_fwd_o.active    = 1'b1;
            es_fwd_o.res_valid = ~inst_r.mem_re;       // load data arrives later
            es_fwd_o.dest      = inst_r.dest;
            es_fwd_o.result    = result;
        end else begin
            es_fwd_o = '0;
        end
    end

endmodule

// ==== tb/tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage import exe_pkg::*; ;

    localparam int MAX_VEC = 64;

    logic      clk;
    logic      reset;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    logic      ms_allowin;
    logic      exc_flush;
    logic      ms_ex;
    logic      data_addr_ok;
    logic      es_allowin;
    logic      es_to_ms_valid;
    es_to_ms_t es_to_ms;
    es_fwd_t   es_fwd;
    logic      data_req;
    data_req_t data_req_data;

    ds_to_es_t  vec_inst   [MAX_VEC];
    logic       vec_flush  [MAX_VEC];
    word_t      exp_result [MAX_VEC];
    logic [2:0] exp_exc    [MAX_VEC];   // of, adel, ades
    strb_t      exp_wstrb  [MAX_VEC];
    word_t      exp_wdata  [MAX_VEC];
    acc_size_t  exp_size   [MAX_VEC];

    int          num_vec;
    int          num_expected;
    int          num_done;
    int          mismatches;
    int          failures;
    int          cycles;
    int          req_count;
    int          inflight[$];           // vector indices held by the stage
    logic [15:0] lfsr;

    exe_stage UUT (
        .clk             (clk),
        .reset           (reset),
        .ds_to_es_valid_i(ds_to_es_valid),
        .ds_to_es_i      (ds_to_es),
        .ms_allowin_i    (ms_allowin),
        .exc_flush_i     (exc_flush),
        .ms_ex_i         (ms_ex),
        .data_addr_ok_i  (data_addr_ok),
        .es_allowin_o    (es_allowin),
        .es_to_ms_valid_o(es_to_ms_valid),
        .es_to_ms_o      (es_to_ms),
        .es_fwd_o        (es_fwd),
        .data_req_o      (data_req),
        .data_req_data_o (data_req_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    function automatic logic expects_request(input int i);
        return (vec_inst[i].mem_re | vec_inst[i].mem_we) & (exp_exc[i][1:0] == 2'b00);
    endfunction

    task automatic check_word(input word_t act, input word_t exp, input string what);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, act, exp);
            mismatches++;
        end
    endtask

    task automatic check_strb(input strb_t act, input strb_t exp, input string what);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp);
            mismatches++;
        end
    endtask

    task automatic check_size(input acc_size_t act, input acc_size_t exp, input string what);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp);
            mismatches++;
        end
    endtask

    task automatic check_idx(input reg_idx_t act, input reg_idx_t exp, input string what);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp);
            mismatches++;
        end
    endtask

    // forwarding path seen by decode for the instruction in the stage
    task automatic check_forward(input int i);
        if (vec_inst[i].gpr_we) begin
            check_flag(es_fwd.active, 1'b1, "fwd active");
            check_flag(es_fwd.res_valid, ~vec_inst[i].mem_re, "fwd res_valid");
            check_idx(es_fwd.dest, vec_inst[i].dest, "fwd dest");
            check_word(es_fwd.result, exp_result[i], "fwd result");
        end else begin
            check_flag(es_fwd.active, 1'b0, "fwd active");
            check_flag(es_fwd.res_valid, 1'b0, "fwd res_valid");
            check_idx(es_fwd.dest, '0, "fwd dest");
            check_word(es_fwd.result, '0, "fwd result");
        end
    endtask

    task automatic load_vectors(input int fd);
        string       line;
        logic [31:0] f[15];
        int          n;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                if (n == 15) begin
                    vec_inst[num_vec].alu_op      = alu_op_e'(f[0][3:0]);
                    vec_inst[num_vec].src1_is_sa  = f[1][7];
                    vec_inst[num_vec].src1_is_pc  = f[1][6];
                    vec_inst[num_vec].src2_is_imm = f[1][5];
                    vec_inst[num_vec].src2_is_8   = f[1][4];
                    vec_inst[num_vec].of_check    = f[1][3];
                    vec_inst[num_vec].gpr_we      = f[1][2];
                    vec_inst[num_vec].mem_re      = f[1][1];
                    vec_inst[num_vec].mem_we      = f[1][0];
                    vec_inst[num_vec].mem_width   = mem_width_e'(f[2][2:0]);
                    vec_inst[num_vec].hilo_op     = hilo_op_e'(f[3][2:0]);
                    vec_inst[num_vec].dest        = f[4][4:0];
                    vec_inst[num_vec].imm         = f[5][15:0];
                    vec_inst[num_vec].rs_value    = f[6];
                    vec_inst[num_vec].rt_value    = f[7];
                    vec_inst[num_vec].pc          = f[8];
                    vec_flush[num_vec]            = f[9][0];
                    exp_result[num_vec]           = f[10];
                    exp_exc[num_vec]              = f[11][2:0];
                    exp_wstrb[num_vec]            = f[12][3:0];
                    exp_wdata[num_vec]            = f[13];
                    exp_size[num_vec]             = f[14][1:0];
                    if (!f[9][0]) num_expected++;   // flushed ones never arrive
                    num_vec++;
                end
            end
        end
    endtask

    // decode side: hands over vectors in file order
    task automatic drive_decode();
        int i;
        for (i = 0; i < num_vec; i++) begin
            ds_to_es_valid = 1'b1;
            ds_to_es       = vec_inst[i];
            @(posedge clk);
            while (!es_allowin) @(posedge clk);
            if (vec_flush[i]) begin
                #1;
                ds_to_es_valid = 1'b0;
                exc_flush      = 1'b1;   // kill it during its first cycle
                @(posedge clk);
                #1;
                exc_flush = 1'b0;
            end else begin
                inflight.push_back(i);
                #1;
            end
        end
        ds_to_es_valid = 1'b0;
    endtask

    // memory side: SRAM handshake, random back-pressure and result checks
    task automatic serve_memory();
        int   idx;
        int   delay_left;
        logic handshake;
        logic b0;
        logic b1;
        delay_left = -1;
        while (num_done < num_expected) begin
            @(posedge clk);
            handshake = data_req & data_addr_ok;
            if (data_req && (inflight.size() == 0 || !expects_request(inflight[0]))) begin
                $display("data request raised with no aligned memory access in the stage");
                failures++;
            end else if (handshake) begin
                idx = inflight[0];
                check_flag(data_req_data.wr, vec_inst[idx].mem_we, "request wr");
                check_word(data_req_data.addr, exp_result[idx], "request addr");
                check_strb(data_req_data.wstrb, exp_wstrb[idx], "request wstrb");
                check_size(data_req_data.size, exp_size[idx], "request size");
                if (vec_inst[idx].mem_we) begin
                    check_word(data_req_data.wdata, exp_wdata[idx], "request wdata");
                end
                req_count++;
            end
            if (es_to_ms_valid && ms_allowin && !exc_flush) begin
                if (inflight.size() == 0) begin
                    $display("an instruction reached the memory stage that should not have");
                    failures++;
                end else begin
                    idx = inflight.pop_front();
                    check_word(es_to_ms.result, exp_result[idx], $sformatf("result %0d", idx));
                    check_word(es_to_ms.pc, vec_inst[idx].pc, "pc");
                    check_idx(es_to_ms.dest, vec_inst[idx].dest, "dest");
                    check_flag(es_to_ms.gpr_we, vec_inst[idx].gpr_we, "gpr_we");
                    check_flag(es_to_ms.mem_re, vec_inst[idx].mem_re, "mem_re");
                    check_word(es_to_ms.rt_value, vec_inst[idx].rt_value, "rt_value");
                    check_flag(es_to_ms.exc_of, exp_exc[idx][2], "exc_of");
                    check_flag(es_to_ms.exc_adel, exp_exc[idx][1], "exc_adel");
                    check_flag(es_to_ms.exc_ades, exp_exc[idx][0], "exc_ades");
                    check_forward(idx);
                    if (req_count != (expects_request(idx) ? 1 : 0)) begin
                        $display("vector %0d made %0d accepted requests", idx, req_count);
                        failures++;
                    end
                    req_count = 0;
                    num_done++;
                end
            end
            #1;
            random_bit(b0);
            random_bit(b1);
            ms_allowin = b0 | b1;            // stalls about one cycle in four
            if (handshake || !data_req) begin
                data_addr_ok = 1'b0;
                delay_left   = -1;
            end else begin
                if (delay_left < 0) begin
                    random_bit(b0);
                    random_bit(b1);
                    delay_left = int'({b0, b1});
                end
                if (delay_left == 0) data_addr_ok = 1'b1;
                else delay_left--;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * num_vec + 100) begin
            $display("run stopped, the stage did not finish the vectors in time");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int fd;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es       = '0;
        ms_allowin     = 1'b1;
        exc_flush      = 1'b0;
        ms_ex          = 1'b0;
        data_addr_ok   = 1'b0;
        num_vec        = 0;
        num_expected   = 0;
        num_done       = 0;
        mismatches     = 0;
        failures       = 0;
        cycles         = 0;
        req_count      = 0;
        lfsr           = 16'd3396;
        fd = $fopen("tb/exe_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            load_vectors(fd);
            $fclose(fd);
            repeat (8) @(posedge clk);
            #1;
            reset = 1'b0;
            fork
                drive_decode();
                serve_memory();
            join
            $display("%0d vectors, %0d mismatches, %0d other failures",
                     num_vec, mismatches, failures);
            if (mismatches == 0 && failures == 0 && num_vec > 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/exe_pkg.sv
hw/exe_alu.sv
hw/store_align.sv
hw/hilo_unit.sv
hw/mem_req_ctrl.sv
hw/exe_stage.sv
tb/tb_exe_stage.sv

// ==== Makefile ====
SOURCES = $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_exe_stage

obj_dir/Vtb_exe_stage: compile.f $(SOURCES)
	verilator --binary --top-module tb_exe_stage -f compile.f

run: obj_dir/Vtb_exe_stage
	@out="$$(./obj_dir/Vtb_exe_stage)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb/exe_testdata.txt ====
# op flags(sa pc imm is8 of gpr mre mwe) width hilo dest imm rs rt pc flush
# result exc(of adel ades) wstrb wdata size
0 04 0 0 01 0000 00000003 00000004 00000100 0 00000007 0 0 00000000 0
0 0c 0 0 02 0000 7fffffff 00000001 00000104 0 80000000 4 0 00000000 0
0 24 0 0 03 0001 7fffffff 00000000 00000108 0 80000000 0 0 00000000 0
1 0c 0 0 04 0000 80000000 00000001 0000010c 0 7fffffff 4 0 00000000 0
1 0c 0 0 05 0000 00000010 00000003 00000110 0 0000000d 0 0 00000000 0
2 04 0 0 06 0000 ffffffff 00000001 00000114 0 00000001 0 0 00000000 0
3 04 0 0 07 0000 ffffffff 00000001 00000118 0 00000000 0 0 00000000 0
4 24 0 0 08 8000 ffffff00 00000000 0000011c 0 00008000 0 0 00000000 0
5 04 0 0 09 0000 f0f0f0f0 0000ffff 00000120 0 0f0f0000 0 0 00000000 0
6 24 0 0 0a 8001 00010000 00000000 00000124 0 00018001 0 0 00000000 0
7 04 0 0 0b 0000 aaaa5555 ffff0000 00000128 0 55555555 0 0 00000000 0
8 84 0 0 0c 0100 00000000 00000011 0000012c 0 00000110 0 0 00000000 0
9 84 0 0 0d 0200 00000000 80000000 00000130 0 00800000 0 0 00000000 0
a 84 0 0 0e 0100 00000000 80000000 00000134 0 f8000000 0 0 00000000 0
b 24 0 0 0f abcd 00000000 00000000 00000138 0 abcd0000 0 0 00000000 0
0 54 0 0 1f 0000 00000000 00000000 0000013c 0 00000144 0 0 00000000 0
0 21 3 0 00 0001 00001000 11223344 00000140 0 00001001 0 2 44444444 0
0 21 3 0 00 0003 00001000 11223344 00000144 0 00001003 0 8 44444444 0
0 21 2 0 00 0002 00001000 11223344 00000148 0 00001002 0 c 33443344 1
0 21 1 0 00 0000 00001000 11223344 0000014c 0 00001000 0 f 11223344 2
0 21 4 0 00 0000 00001000 11223344 00000150 0 00001000 0 1 00000011 0
0 21 4 0 00 0002 00001000 11223344 00000154 0 00001002 0 7 00112233 2
0 21 5 0 00 0001 00001000 11223344 00000158 0 00001001 0 e 22334400 2
0 21 5 0 00 0003 00001000 11223344 0000015c 0 00001003 0 8 44000000 0
0 26 1 0 10 0000 00001000 00000000 00000160 0 00001000 0 0 00000000 2
0 26 3 0 11 0003 00001000 00000000 00000164 0 00001003 0 0 00000000 0
0 26 2 0 12 0001 00001000 00000000 00000168 0 00001001 2 0 00000000 0
0 26 1 0 13 0002 00001000 00000000 0000016c 0 00001002 2 0 00000000 0
0 21 2 0 00 0003 00001000 11223344 00000170 0 00001003 1 0 00000000 0
0 21 1 0 00 0001 00001000 11223344 00000174 0 00001001 1 0 00000000 0
0 00 0 1 00 0000 fffffffe 00000003 00000178 0 00000001 0 0 00000000 0
0 04 0 5 14 0000 00000000 00000000 0000017c 0 ffffffff 0 0 00000000 0
0 04 0 6 15 0000 00000000 00000000 00000180 0 fffffffa 0 0 00000000 0
0 00 0 2 00 0000 fffffffe 00000003 00000184 0 00000001 0 0 00000000 0
0 04 0 5 16 0000 00000000 00000000 00000188 0 00000002 0 0 00000000 0
0 00 0 3 00 0000 12345678 00000000 0000018c 0 12345678 0 0 00000000 0
0 00 0 4 00 0000 9abcdef0 00000000 00000190 0 9abcdef0 0 0 00000000 0
0 04 0 5 17 0000 00000000 00000000 00000194 0 12345678 0 0 00000000 0
0 04 0 6 18 0000 00000000 00000000 00000198 0 9abcdef0 0 0 00000000 0
0 00 0 3 00 0000 deadbeef 00000000 0000019c 1 deadbeef 0 0 00000000 0
0 04 0 5 19 0000 00000000 00000000 000001a0 0 12345678 0 0 00000000 0
0 21 1 0 00 0000 00001000 11223344 000001a4 1 00001000 0 f 11223344 2
0 26 1 0 1a 0004 00001000 00000000 000001a8 0 00001004 0 0 00000000 2
